// ==== hw/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_id_t;

  // alu operation select, decoded in execute
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_t;

  // major opcodes
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // funct3 for alu ops
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;  // srl / sra
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 marking sub and sra
  localparam logic [6:0] F7_ALT = 7'b0100000;

  // addi x0, x0, 0
  localparam word_t NOP_INST = 32'h0000_0013;

  // ecall exits when a7 holds this
  localparam word_t   HALT_CODE = 32'd10;
  localparam reg_id_t ECALL_REG = 5'd17;

endpackage

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import cpu_pkg::*; #(
  parameter int IMEM_WORDS = 64
) (
  input  wire   clk,
  input  wire   arst_n,
  input  logic  stall,
  input  logic  halt,
  input  logic  prog_we,
  input  word_t prog_addr,
  input  word_t prog_data,
  output word_t id_inst,
  output word_t id_pc
);

  localparam int AW = $clog2(IMEM_WORDS);

  word_t imem [IMEM_WORDS];
  word_t pc;
  word_t if_inst;

  // load port, byte address like the pc
  always_ff @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr[2 +: AW]] <= prog_data;
    end
  end

  assign if_inst = imem[pc[2 +: AW]];

  // no branches, so the next pc is always pc + 4
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (!stall && !halt) begin
      pc <= pc + 32'd4;
    end
  end

  // IF/ID
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_inst <= NOP_INST;
      id_pc   <= '0;
    end else if (!stall && !halt) begin
      id_inst <= if_inst;
      id_pc   <= pc;
    end
  end

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_pkg::*; (
  input  wire     clk,
  input  wire     arst_n,
  input  logic    halt,
  input  word_t   id_inst,
  input  logic    wb_en,
  input  reg_id_t wb_rd,
  input  word_t   wb_data,
  input  reg_id_t ex_rd,
  input  logic    ex_mem_read,
  input  logic    ex_wb_en,
  input  reg_id_t mem_rd,
  input  logic    mem_wb_en,
  input  reg_id_t dbg_addr,
  output logic    stall,
  output word_t   dbg_data,
  output logic    ex_ctl_wb,
  output logic    ex_ctl_mem_read,
  output logic    ex_ctl_mem_write,
  output logic    ex_ctl_op2_imm,
  output logic    ex_ctl_halt,
  output word_t   ex_rs1_val,
  output word_t   ex_rs2_val,
  output reg_id_t ex_rs1_id,
  output reg_id_t ex_rs2_id,
  output reg_id_t ex_rd_id,
  output word_t   ex_inst,
  output word_t   ex_imm
);

  logic [6:0] opcode;
  logic       dec_wb, dec_mem_read, dec_mem_write, dec_op2_imm;
  logic       is_ecall, rs1_used, rs2_used;
  logic       ecall_halt;
  logic       load_use, ecall_wait;
  reg_id_t    rs1_id, rs2_id;
  word_t      rs1_val, rs2_val;
  word_t      imm;
  word_t      regs [32];

  // x0 reads zero, a write in flight from MEM/WB is bypassed
  function automatic word_t rf_read(input reg_id_t id);
    word_t val;
    if (id == '0) begin
      val = '0;
    end else if (wb_en && wb_rd == id) begin
      val = wb_data;
    end else begin
      val = regs[id];
    end
    return val;
  endfunction

  assign opcode = id_inst[6:0];

  always_comb begin
    dec_wb        = 1'b0;
    dec_mem_read  = 1'b0;
    dec_mem_write = 1'b0;
    dec_op2_imm   = 1'b0;
    is_ecall      = 1'b0;
    rs1_used      = 1'b0;
    rs2_used      = 1'b0;
    case (opcode)
      OP_REG: begin
        dec_wb   = 1'b1;
        rs1_used = 1'b1;
        rs2_used = 1'b1;
      end
      OP_IMM: begin
        dec_wb      = 1'b1;
        dec_op2_imm = 1'b1;
        rs1_used    = 1'b1;
      end
      OP_LOAD: begin
        dec_wb       = 1'b1;
        dec_mem_read = 1'b1;
        dec_op2_imm  = 1'b1;
        rs1_used     = 1'b1;
      end
      OP_STORE: begin
        dec_mem_write = 1'b1;
        dec_op2_imm   = 1'b1;
        rs1_used      = 1'b1;
        rs2_used      = 1'b1;
      end
      OP_SYSTEM: begin
        is_ecall = 1'b1;
        rs1_used = 1'b1; // reads a7
      end
      default: ;
    endcase
  end

  assign rs1_id = is_ecall ? ECALL_REG : id_inst[19:15];
  assign rs2_id = id_inst[24:20];

  // S-type splits the offset, everything else here is I-type
  assign imm = (opcode == OP_STORE) ? {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]}
                                    : {{20{id_inst[31]}}, id_inst[31:20]};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  always_comb begin
    rs1_val  = rf_read(rs1_id);
    rs2_val  = rf_read(rs2_id);
    dbg_data = rf_read(dbg_addr);
  end

  assign ecall_halt = is_ecall && (rs1_val == HALT_CODE);

  // load result not ready until MEM, one bubble needed
  assign load_use = ex_mem_read && (ex_rd != '0) &&
                    ((rs1_used && ex_rd == rs1_id) || (rs2_used && ex_rd == rs2_id));

  // a7 compared here in decode, so wait for older writers of it
  assign ecall_wait = is_ecall && ((ex_wb_en && ex_rd == ECALL_REG) ||
                                   (mem_wb_en && mem_rd == ECALL_REG));

  assign stall = load_use || ecall_wait;

  // ID/EX control, bubble on stall
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_ctl_wb        <= 1'b0;
      ex_ctl_mem_read  <= 1'b0;
      ex_ctl_mem_write <= 1'b0;
      ex_ctl_op2_imm   <= 1'b0;
      ex_ctl_halt      <= 1'b0;
      ex_rs1_id        <= '0;
      ex_rs2_id        <= '0;
      ex_rd_id         <= '0;
    end else if (!halt) begin
      ex_ctl_wb        <= dec_wb && !stall;
      ex_ctl_mem_read  <= dec_mem_read && !stall;
      ex_ctl_mem_write <= dec_mem_write && !stall;
      ex_ctl_op2_imm   <= dec_op2_imm && !stall;
      ex_ctl_halt      <= ecall_halt && !stall;
      ex_rs1_id        <= rs1_id;
      ex_rs2_id        <= rs2_id;
      ex_rd_id         <= id_inst[11:7];
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    if (!halt) begin
      ex_rs1_val <= rs1_val;
      ex_rs2_val <= rs2_val;
      ex_inst    <= id_inst;
      ex_imm     <= imm;
    end
  end

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
  input  wire     clk,
  input  wire     arst_n,
  input  logic    halt,
  input  logic    ex_ctl_wb,
  input  logic    ex_ctl_mem_read,
  input  logic    ex_ctl_mem_write,
  input  logic    ex_ctl_op2_imm,
  input  logic    ex_ctl_halt,
  input  word_t   ex_rs1_val,
  input  word_t   ex_rs2_val,
  input  reg_id_t ex_rs1_id,
  input  reg_id_t ex_rs2_id,
  input  reg_id_t ex_rd_id,
  input  word_t   ex_inst,
  input  word_t   ex_imm,
  input  logic    wb_en,
  input  reg_id_t wb_rd,
  input  word_t   wb_data,
  output reg_id_t ex_rd,
  output logic    ex_mem_read,
  output logic    ex_wb_en,
  output logic    mem_ctl_wb,
  output logic    mem_ctl_mem_read,
  output logic    mem_ctl_mem_write,
  output logic    mem_ctl_halt,
  output word_t   mem_alu_result,
  output word_t   mem_store_data,
  output reg_id_t mem_rd_id
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  alu_op_t    alu_op;
  logic       ex_forwardable;
  word_t      op_a, rs2_fwd, op_b;
  word_t      alu_result;

  // youngest producer wins, loads in EX/MEM have no data yet
  function automatic word_t fwd_sel(input reg_id_t id, input word_t reg_val);
    word_t val;
    if (id != '0 && ex_forwardable && mem_rd_id == id) begin
      val = mem_alu_result;
    end else if (id != '0 && wb_en && wb_rd == id) begin
      val = wb_data;
    end else begin
      val = reg_val;
    end
    return val;
  endfunction

  assign opcode = ex_inst[6:0];
  assign funct3 = ex_inst[14:12];
  assign funct7 = ex_inst[31:25];

  always_comb begin
    alu_op = ALU_ADD; // loads, stores, ecall
    if (opcode == OP_REG || opcode == OP_IMM) begin
      case (funct3)
        F3_ADD_SUB: alu_op = (opcode == OP_REG && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
        F3_SLL:     alu_op = ALU_SLL;
        F3_SLT:     alu_op = ALU_SLT;
        F3_SLTU:    alu_op = ALU_SLTU;
        F3_XOR:     alu_op = ALU_XOR;
        F3_SR:      alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL; // srai has the bit too
        F3_OR:      alu_op = ALU_OR;
        F3_AND:     alu_op = ALU_AND;
        default:    alu_op = ALU_ADD;
      endcase
    end
  end

  assign ex_forwardable = mem_ctl_wb && !mem_ctl_mem_read;

  always_comb begin
    op_a    = fwd_sel(ex_rs1_id, ex_rs1_val);
    rs2_fwd = fwd_sel(ex_rs2_id, ex_rs2_val);
  end

  assign op_b = ex_ctl_op2_imm ? ex_imm : rs2_fwd;

  always_comb begin
    case (alu_op)
      ALU_ADD:  alu_result = op_a + op_b;
      ALU_SUB:  alu_result = op_a - op_b;
      ALU_AND:  alu_result = op_a & op_b;
      ALU_OR:   alu_result = op_a | op_b;
      ALU_XOR:  alu_result = op_a ^ op_b;
      ALU_SLL:  alu_result = op_a << op_b[4:0];
      ALU_SRL:  alu_result = op_a >> op_b[4:0];
      ALU_SRA:  alu_result = word_t'($signed(op_a) >>> op_b[4:0]);
      ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_result = {31'b0, op_a < op_b};
      default:  alu_result = '0;
    endcase
  end

  // seen by decode for hazard checks
  assign ex_rd       = ex_rd_id;
  assign ex_mem_read = ex_ctl_mem_read;
  assign ex_wb_en    = ex_ctl_wb;

  // EX/MEM
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_ctl_wb        <= 1'b0;
      mem_ctl_mem_read  <= 1'b0;
      mem_ctl_mem_write <= 1'b0;
      mem_ctl_halt      <= 1'b0;
      mem_rd_id         <= '0;
    end else if (!halt) begin
      mem_ctl_wb        <= ex_ctl_wb;
      mem_ctl_mem_read  <= ex_ctl_mem_read;
      mem_ctl_mem_write <= ex_ctl_mem_write;
      mem_ctl_halt      <= ex_ctl_halt;
      mem_rd_id         <= ex_rd_id;
    end
  end

  always_ff @(posedge clk) begin
    if (!halt) begin
      mem_alu_result <= alu_result;
      mem_store_data <= rs2_fwd;
    end
  end

endmodule

`default_nettype wire

// ==== hw/memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_stage import cpu_pkg::*; #(
  parameter int DMEM_WORDS = 64
) (
  input  wire     clk,
  input  wire     arst_n,
  input  logic    halt,
  input  logic    mem_ctl_wb,
  input  logic    mem_ctl_mem_read,
  input  logic    mem_ctl_mem_write,
  input  logic    mem_ctl_halt,
  input  word_t   mem_alu_result,
  input  word_t   mem_store_data,
  input  reg_id_t mem_rd_id,
  input  word_t   dmem_dbg_addr,
  output reg_id_t mem_rd,
  output logic    mem_wb_en,
  output logic    wb_en,
  output reg_id_t wb_rd,
  output word_t   wb_data,
  output logic    is_halted,
  output word_t   dmem_dbg_data
);

  localparam int AW = $clog2(DMEM_WORDS);

  word_t dmem [DMEM_WORDS];
  word_t load_data;

  // word access only, byte offset bits ignored
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (mem_ctl_mem_write && !halt) begin
      dmem[mem_alu_result[2 +: AW]] <= mem_store_data;
    end
  end

  assign load_data     = dmem[mem_alu_result[2 +: AW]];
  assign dmem_dbg_data = dmem[dmem_dbg_addr[2 +: AW]];

  assign mem_rd    = mem_rd_id;
  assign mem_wb_en = mem_ctl_wb;

  // MEM/WB, halt bit sticks until reset since everything freezes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_en     <= 1'b0;
      wb_rd     <= '0;
      is_halted <= 1'b0;
    end else if (!halt) begin
      wb_en     <= mem_ctl_wb;
      wb_rd     <= mem_rd_id;
      is_halted <= mem_ctl_halt;
    end
  end

  always_ff @(posedge clk) begin
    if (!halt) begin
      wb_data <= mem_ctl_mem_read ? load_data : mem_alu_result;
    end
  end

endmodule

`default_nettype wire

// ==== hw/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu import cpu_pkg::*; #(
  parameter int IMEM_WORDS = 64,
  parameter int DMEM_WORDS = 64
) (
  input  wire     clk,
  input  wire     arst_n,
  input  logic    prog_we,
  input  word_t   prog_addr,
  input  word_t   prog_data,
  input  reg_id_t dbg_addr,
  input  word_t   dmem_dbg_addr,
  output logic    is_halted,
  output word_t   dbg_data,
  output word_t   dmem_dbg_data
);

  word_t   id_inst;
  logic    stall;
  logic    ex_ctl_wb, ex_ctl_mem_read, ex_ctl_mem_write, ex_ctl_op2_imm, ex_ctl_halt;
  word_t   ex_rs1_val, ex_rs2_val, ex_inst, ex_imm;
  reg_id_t ex_rs1_id, ex_rs2_id, ex_rd_id;
  reg_id_t ex_rd, mem_rd;
  logic    ex_mem_read, ex_wb_en, mem_wb_en;
  logic    mem_ctl_wb, mem_ctl_mem_read, mem_ctl_mem_write, mem_ctl_halt;
  word_t   mem_alu_result, mem_store_data;
  reg_id_t mem_rd_id;
  logic    wb_en;
  reg_id_t wb_rd;
  word_t   wb_data;

  fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) fetch_i (
    .clk, .arst_n, .stall,
    .halt      (is_halted),
    .prog_we, .prog_addr, .prog_data,
    .id_inst,
    .id_pc     ()  // pc of IF/ID, no consumer without branches
  );

  decode_stage decode_i (
    .clk, .arst_n,
    .halt (is_halted),
    .id_inst, .wb_en, .wb_rd, .wb_data,
    .ex_rd, .ex_mem_read, .ex_wb_en, .mem_rd, .mem_wb_en,
    .dbg_addr, .stall, .dbg_data,
    .ex_ctl_wb, .ex_ctl_mem_read, .ex_ctl_mem_write, .ex_ctl_op2_imm, .ex_ctl_halt,
    .ex_rs1_val, .ex_rs2_val, .ex_rs1_id, .ex_rs2_id, .ex_rd_id, .ex_inst, .ex_imm
  );

  execute_stage execute_i (
    .clk, .arst_n,
    .halt (is_halted),
    .ex_ctl_wb, .ex_ctl_mem_read, .ex_ctl_mem_write, .ex_ctl_op2_imm, .ex_ctl_halt,
    .ex_rs1_val, .ex_rs2_val, .ex_rs1_id, .ex_rs2_id, .ex_rd_id, .ex_inst, .ex_imm,
    .wb_en, .wb_rd, .wb_data,
    .ex_rd, .ex_mem_read, .ex_wb_en,
    .mem_ctl_wb, .mem_ctl_mem_read, .mem_ctl_mem_write, .mem_ctl_halt,
    .mem_alu_result, .mem_store_data, .mem_rd_id
  );

  memory_stage #(.DMEM_WORDS(DMEM_WORDS)) memory_i (
    .clk, .arst_n,
    .halt (is_halted),
    .mem_ctl_wb, .mem_ctl_mem_read, .mem_ctl_mem_write, .mem_ctl_halt,
    .mem_alu_result, .mem_store_data, .mem_rd_id, .dmem_dbg_addr,
    .mem_rd, .mem_wb_en, .wb_en, .wb_rd, .wb_data,
    .is_halted, .dmem_dbg_data
  );

endmodule

`default_nettype wire

// ==== dv/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

  localparam int    RESET_CYCLES = 16;
  localparam int    HALT_TIMEOUT = 500;
  localparam string VEC_FILE     = "dv/cpu_vectors.txt";

  logic    clk;
  logic    arst_n;
  logic    prog_we;
  word_t   prog_addr;
  word_t   prog_data;
  reg_id_t dbg_addr;
  word_t   dmem_dbg_addr;
  logic    is_halted;
  word_t   dbg_data;
  word_t   dmem_dbg_data;

  // one record from the vectors file
  word_t   prog_addr_q[$];
  word_t   prog_data_q[$];
  reg_id_t reg_id_q[$];
  word_t   reg_exp_q[$];
  word_t   mem_addr_q[$];
  word_t   mem_exp_q[$];
  logic    exp_halt;

  int reg_errs  = 0;
  int mem_errs  = 0;
  int halt_errs = 0;
  int timeouts  = 0;
  int file_errs = 0;
  int n_records = 0;

  cpu cpu_i (
    .clk, .arst_n,
    .prog_we, .prog_addr, .prog_data,
    .dbg_addr, .dmem_dbg_addr,
    .is_halted, .dbg_data, .dmem_dbg_data
  );

  always #10 clk = ~clk;

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_reg(input reg_id_t id, input word_t exp);
    next_cycle();
    dbg_addr = id;
    #1;
    if (dbg_data !== exp) begin
      $display("ERR dbg_data x%0d: got %h, expected %h", id, dbg_data, exp);
      reg_errs++;
    end
  endtask

  task automatic check_mem(input word_t addr, input word_t exp);
    next_cycle();
    dmem_dbg_addr = addr;
    #1;
    if (dmem_dbg_data !== exp) begin
      $display("ERR dmem_dbg_data @%h: got %h, expected %h", addr, dmem_dbg_data, exp);
      mem_errs++;
    end
  endtask

  task automatic check_halt(input logic exp);
    next_cycle();
    if (is_halted !== exp) begin
      $display("ERR is_halted: got %h, expected %h", is_halted, exp);
      halt_errs++;
    end
  endtask

  task automatic run_record();
    int  cycles;
    bit  done;
    next_cycle();
    arst_n = 1'b0;
    cycles = 0;
    // program goes in while the core is held
    foreach (prog_addr_q[i]) begin
      prog_we   = 1'b1;
      prog_addr = prog_addr_q[i];
      prog_data = prog_data_q[i];
      next_cycle();
      cycles++;
    end
    prog_we = 1'b0;
    while (cycles < RESET_CYCLES) begin
      next_cycle();
      cycles++;
    end
    // reset state, nothing has run yet
    check_halt(1'b0);
    foreach (reg_id_q[i]) check_reg(reg_id_q[i], '0);
    foreach (mem_addr_q[i]) check_mem(mem_addr_q[i], '0);
    next_cycle();
    arst_n = 1'b1;

    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < HALT_TIMEOUT) begin
      next_cycle();
      cycles++;
      done = is_halted;
    end
    if (!done) begin
      $display("record %0d: the core did not halt within %0d cycles", n_records, HALT_TIMEOUT);
      timeouts++;
    end else begin
      $display("record %0d: halted after %0d cycles", n_records, cycles);
      check_halt(exp_halt);
      foreach (reg_id_q[i]) check_reg(reg_id_q[i], reg_exp_q[i]);
      foreach (mem_addr_q[i]) check_mem(mem_addr_q[i], mem_exp_q[i]);
    end
  endtask

  task automatic bad_line(input logic [7:0] tag);
    $display("vectors file: malformed line with tag %c", tag);
    file_errs++;
  endtask

  initial begin
    int         fd;
    int         code;
    int         ch;
    logic [7:0] tag;
    word_t      f1, f2;
    clk           = 1'b0;
    arst_n        = 1'b0;
    prog_we       = 1'b0;
    prog_addr     = '0;
    prog_data     = '0;
    dbg_addr      = '0;
    dmem_dbg_addr = '0;
    exp_halt      = 1'b1;

    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("cannot open %s", VEC_FILE);
      file_errs++;
    end else begin
      code = $fscanf(fd, " %c", tag);
      while (code == 1) begin
        case (tag)
          "#": begin // comment up to end of line
            ch = $fgetc(fd);
            while (ch != 10 && ch != -1) ch = $fgetc(fd);
          end
          "P": begin
            code = $fscanf(fd, "%h %h", f1, f2);
            if (code != 2) bad_line(tag);
            prog_addr_q.push_back(f1);
            prog_data_q.push_back(f2);
          end
          "R": begin
            code = $fscanf(fd, "%d %h", f1, f2);
            if (code != 2) bad_line(tag);
            reg_id_q.push_back(reg_id_t'(f1));
            reg_exp_q.push_back(f2);
          end
          "M": begin
            code = $fscanf(fd, "%h %h", f1, f2);
            if (code != 2) bad_line(tag);
            mem_addr_q.push_back(f1);
            mem_exp_q.push_back(f2);
          end
          "H": begin
            code = $fscanf(fd, "%h", f1);
            if (code != 1) bad_line(tag);
            exp_halt = f1[0];
          end
          "E": begin
            run_record();
            n_records++;
            prog_addr_q.delete();
            prog_data_q.delete();
            reg_id_q.delete();
            reg_exp_q.delete();
            mem_addr_q.delete();
            mem_exp_q.delete();
            exp_halt = 1'b1;
          end
          default: bad_line(tag);
        endcase
        code = $fscanf(fd, " %c", tag);
      end
      $fclose(fd);
    end
    if (n_records == 0) begin
      $display("no test records were run");
      file_errs++;
    end

    $display("records %0d, errors: reg %0d, mem %0d, halt %0d, timeout %0d, file %0d",
             n_records, reg_errs, mem_errs, halt_errs, timeouts, file_errs);
    if (reg_errs + mem_errs + halt_errs + timeouts + file_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/cpu_vectors.txt ====
# P byte_addr inst (hex) | R reg (dec) expected (hex) | M byte_addr expected (hex)
# H halted (0/1) | E ends a record | text after # is ignored
# alu ops, R and I forms, shift amounts from the low 5 bits, x0 writes
P 00 06400093 # addi x1,x0,100
P 04 ff900113 # addi x2,x0,-7
P 08 002081b3 # add  x3,x1,x2
P 0c 40208233 # sub  x4,x1,x2
P 10 0020f2b3 # and  x5,x1,x2
P 14 0020e333 # or   x6,x1,x2
P 18 0020c3b3 # xor  x7,x1,x2
P 1c 02400493 # addi x9,x0,36
P 20 00909533 # sll  x10,x1,x9
P 24 009155b3 # srl  x11,x2,x9
P 28 40915633 # sra  x12,x2,x9
P 2c 001126b3 # slt  x13,x2,x1
P 30 00113733 # sltu x14,x2,x1
P 34 0f017793 # andi x15,x2,0xf0
P 38 f000e813 # ori  x16,x1,-256
P 3c fff0c913 # xori x18,x1,-1
P 40 00309993 # slli x19,x1,3
P 44 01c15a13 # srli x20,x2,28
P 48 40115a93 # srai x21,x2,1
P 4c ffa12b13 # slti x22,x2,-6
P 50 fff0bb93 # sltiu x23,x1,-1
P 54 00508013 # addi x0,x1,5
P 58 00100c33 # add  x24,x0,x1
P 5c 00a00893 # addi x17,x0,10
P 60 00000073 # ecall
R 3 0000005d
R 4 0000006b
R 5 00000060
R 6 fffffffd
R 7 ffffff9d
R 10 00000640
R 11 0fffffff
R 12 ffffffff
R 13 00000001
R 14 00000000
R 15 000000f0
R 16 ffffff64
R 18 ffffff9b
R 19 00000320
R 20 0000000f
R 21 fffffffc
R 22 00000001
R 23 00000001
R 0 00000000
R 24 00000064
H 1
E
# forwarding at distance 1, 2 and 3
P 00 00500093 # addi x1,x0,5
P 04 00108113 # addi x2,x1,1
P 08 00208193 # addi x3,x1,2
P 0c 00208233 # add  x4,x1,x2
P 10 003202b3 # add  x5,x4,x3
P 14 401282b3 # sub  x5,x5,x1
P 18 00528333 # add  x6,x5,x5
P 1c 00a00893 # addi x17,x0,10
P 20 00000073 # ecall
R 2 00000006
R 3 00000007
R 4 0000000b
R 5 0000000d
R 6 0000001a
H 1
E
# stores, loads and load-use stalls
P 00 05500093 # addi x1,x0,0x55
P 04 00800113 # addi x2,x0,8
P 08 00112223 # sw   x1,4(x2)
P 0c 00202023 # sw   x2,0(x0)
P 10 00412183 # lw   x3,4(x2)
P 14 00318233 # add  x4,x3,x3
P 18 fe412e23 # sw   x4,-4(x2)
P 1c 00002283 # lw   x5,0(x0)
P 20 0042a303 # lw   x6,4(x5)
P 24 00a00893 # addi x17,x0,10
P 28 00000073 # ecall
R 3 00000055
R 4 000000aa
R 5 00000008
R 6 00000055
M 00 00000008
M 04 000000aa
M 0c 00000055
H 1
E
# halt right after x17 is set, nothing younger commits
P 00 00a00893 # addi x17,x0,10
P 04 00000073 # ecall
P 08 00100393 # addi x7,x0,1
P 0c 00200413 # addi x8,x0,2
P 10 00702023 # sw   x7,0(x0)
R 17 0000000a
R 7 00000000
R 8 00000000
M 00 00000000
H 1
E
# ecall with x17 = 3 runs on, later halt with x17 from a load
P 00 00300893 # addi x17,x0,3
P 04 00000073 # ecall
P 08 00700513 # addi x10,x0,7
P 0c 00150593 # addi x11,x10,1
P 10 00a00613 # addi x12,x0,10
P 14 00c02823 # sw   x12,16(x0)
P 18 01002883 # lw   x17,16(x0)
P 1c 00000073 # ecall
P 20 00100693 # addi x13,x0,1
R 10 00000007
R 11 00000008
R 12 0000000a
R 17 0000000a
R 13 00000000
M 10 0000000a
H 1
E

// ==== sim.f ====
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/cpu.sv
dv/cpu_tb.sv

// ==== Makefile ====
.PHONY: run clean

run: obj_dir/Vcpu_tb
	@out="$$(./obj_dir/Vcpu_tb)"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

obj_dir/Vcpu_tb: sim.f $(wildcard hw/*.sv) dv/cpu_tb.sv
	verilator --binary --timing -f sim.f --top-module cpu_tb -Mdir obj_dir

clean:
	rm -rf obj_dir
